// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pe_type_d
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# run prints the log and fails unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+hdl
hdl/pe_pkg.sv
hdl/register_pipe.sv
hdl/fp_round_pack.sv
hdl/fp_div_pipe.sv
hdl/fp_sqrt_pipe.sv
hdl/pe_type_d.sv
testbench/tb_pe_type_d.sv

// File: hdl/fp_div_pipe.sv
`include "pe_settings.svh"

module fp_div_pipe (
    input  logic          clk,
    input  logic          rst_n,
    input  pe_pkg::fp64_t a,
    input  pe_pkg::fp64_t b,
    output pe_pkg::fp64_t q
);
    import pe_pkg::*;

    localparam int N  = `PE_ITER_BITS;
    localparam int MW = FP_FRAC_W + 1; // significand with hidden one
    localparam int RW = MW + 1;        // partial remainder, holds 2*divisor

    logic [FP_EXP_W-1:0] a_exp, b_exp;
    logic                a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic                in_sign;
    logic signed [12:0]  in_exp;
    logic                in_special;
    fp64_t               in_special_val;

    // stage 0 is the unpack register, 1..N the iterations
    logic [RW-1:0]       rem_q [0:N];
    logic [MW-1:0]       dvs_q [0:N];
    logic [N-1:0]        quo_q [0:N];
    logic                sign_q [0:N];
    logic signed [12:0]  exp_q [0:N];
    logic                special_q [0:N];
    fp64_t               special_val_q [0:N];

    logic                q_bit [1:N];
    logic [RW-1:0]       nxt_rem [1:N];
    fp64_t               z;

    always_comb begin
        a_exp   = a[FP_EXP_W+FP_FRAC_W-1:FP_FRAC_W];
        b_exp   = b[FP_EXP_W+FP_FRAC_W-1:FP_FRAC_W];
        a_zero  = (a_exp == '0);  // subnormal counts as zero
        b_zero  = (b_exp == '0);
        a_inf   = (a_exp == '1) && (a[FP_FRAC_W-1:0] == '0);
        b_inf   = (b_exp == '1) && (b[FP_FRAC_W-1:0] == '0);
        a_nan   = (a_exp == '1) && (a[FP_FRAC_W-1:0] != '0);
        b_nan   = (b_exp == '1) && (b[FP_FRAC_W-1:0] != '0);
        in_sign = a[63] ^ b[63];
        in_exp  = $signed({2'b00, a_exp}) - $signed({2'b00, b_exp}) + 13'(FP_BIAS);

        in_special = 1'b1;
        if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
            in_special_val = FP_QNAN;                                   // invalid
        end else if (a_inf || b_zero) begin
            in_special_val = {in_sign, {FP_EXP_W{1'b1}}, {FP_FRAC_W{1'b0}}}; // signed inf
        end else if (a_zero || b_inf) begin
            in_special_val = {in_sign, {(FP_EXP_W+FP_FRAC_W){1'b0}}};   // signed zero
        end else begin
            in_special     = 1'b0;
            in_special_val = '0;
        end
    end

    // one restoring step per stage
    always_comb begin
        for (int i = 1; i <= N; i++) begin
            q_bit[i]   = (rem_q[i-1] >= RW'(dvs_q[i-1]));
            nxt_rem[i] = (q_bit[i] ? rem_q[i-1] - RW'(dvs_q[i-1]) : rem_q[i-1]) << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= N; i++) begin
                rem_q[i]         <= '0;
                dvs_q[i]         <= '0;
                quo_q[i]         <= '0;
                sign_q[i]        <= 1'b0;
                exp_q[i]         <= '0;
                special_q[i]     <= 1'b0;
                special_val_q[i] <= '0;
            end
            q <= '0;
        end else begin
            rem_q[0]         <= {1'b0, 1'b1, a[FP_FRAC_W-1:0]}; // dividend significand
            dvs_q[0]         <= {1'b1, b[FP_FRAC_W-1:0]};
            quo_q[0]         <= '0;
            sign_q[0]        <= in_sign;
            exp_q[0]         <= in_exp;
            special_q[0]     <= in_special;
            special_val_q[0] <= in_special_val;
            for (int i = 1; i <= N; i++) begin
                rem_q[i]         <= nxt_rem[i];
                quo_q[i]         <= {quo_q[i-1][N-2:0], q_bit[i]}; // msb first
                dvs_q[i]         <= dvs_q[i-1];
                sign_q[i]        <= sign_q[i-1];
                exp_q[i]         <= exp_q[i-1];
                special_q[i]     <= special_q[i-1];
                special_val_q[i] <= special_val_q[i-1];
            end
            q <= z; // round stage
        end
    end

    fp_round_pack i_fp_round_pack (
        .sign        (sign_q[N]),
        .exp         (exp_q[N]),
        .mant        (quo_q[N]),
        .sticky      (|rem_q[N]),   // inexact tail
        .special     (special_q[N]),
        .special_val (special_val_q[N]),
        .z           (z)
    );

    // a zero divisor must never reach the iterations as a normal op
    assert property (@(posedge clk) disable iff (!rst_n) (b_zero |=> special_q[0]))
        else $error("fp_div_pipe: zero divisor without special flag");

endmodule

// File: hdl/fp_round_pack.sv
`include "pe_settings.svh"

module fp_round_pack (
    input  logic                      sign,
    input  logic signed [12:0]        exp,
    input  logic [`PE_ITER_BITS-1:0]  mant,
    input  logic                      sticky,
    input  logic                      special,
    input  pe_pkg::fp64_t             special_val,
    output pe_pkg::fp64_t             z
);
    import pe_pkg::*;

    localparam int N    = `PE_ITER_BITS;
    localparam int EMAX = (1 << FP_EXP_W) - 1; // all-ones exponent, inf/nan

    logic [N-1:0]           m_norm;   // leading one at the top
    logic signed [12:0]     e_norm;
    logic [FP_FRAC_W:0]     sig;      // 53 bits incl hidden one
    logic                   guard;
    logic                   rest;     // round bit or'd with sticky
    logic                   round_up;
    logic [FP_FRAC_W+1:0]   rnd;      // extra bit catches carry out
    logic signed [12:0]     e_rnd;

    always_comb begin
        if (mant[N-1]) begin
            m_norm = mant;
            e_norm = exp;
        end else begin
            m_norm = mant << 1;    // quotient below one
            e_norm = exp - 13'sd1;
        end
        sig      = m_norm[N-1 -: FP_FRAC_W+1];
        guard    = m_norm[N-2-FP_FRAC_W];
        rest     = (|m_norm[N-3-FP_FRAC_W:0]) | sticky;
        round_up = guard & (rest | sig[0]); // ties go to even
        rnd      = {1'b0, sig} + (FP_FRAC_W+2)'(round_up);
        e_rnd    = e_norm + $signed({12'd0, rnd[FP_FRAC_W+1]}); // 1.111.. rolled to 10.000
    end

    always_comb begin
        if (special) begin
            z = special_val;
        end else if (e_rnd >= 13'(EMAX)) begin
            z = {sign, {FP_EXP_W{1'b1}}, {FP_FRAC_W{1'b0}}};  // overflow to inf
        end else if (e_rnd <= 13'sd0) begin
            z = {sign, {(FP_EXP_W+FP_FRAC_W){1'b0}}};         // flush to signed zero
        end else begin
            z = {sign, e_rnd[FP_EXP_W-1:0], rnd[FP_FRAC_W-1:0]}; // carry case gives zero frac
        end
    end

    // both pipelines hand over a mantissa with one of the top two bits set
    always_comb begin
        if (!special && exp > 13'sd0 && exp < 13'(EMAX)) begin
            assert final (m_norm[N-1])
                else $error("fp_round_pack: leading bit lost after normalization");
        end
    end

endmodule

// File: hdl/fp_sqrt_pipe.sv
`include "pe_settings.svh"

module fp_sqrt_pipe (
    input  logic          clk,
    input  logic          rst_n,
    input  pe_pkg::fp64_t a,
    output pe_pkg::fp64_t r
);
    import pe_pkg::*;

    localparam int N     = `PE_ITER_BITS;
    localparam int RADW  = FP_FRAC_W + 2; // radicand, 2 integer bits
    localparam int RW    = N + 4;         // remainder, bounded by 2*root+1 shifted twice

    logic [FP_EXP_W-1:0] a_exp;
    logic                a_zero, a_inf, a_nan;
    logic                sq_odd;          // unbiased exponent odd
    logic signed [12:0]  e_unb;
    logic signed [12:0]  in_exp;
    logic                in_special;
    fp64_t               in_special_val;

    // stage 0 is the unpack register, 1..N the iterations
    logic [RADW-1:0]     rad_q [0:N];
    logic [RW-1:0]       rem_q [0:N];
    logic [N-1:0]        root_q [0:N];
    logic signed [12:0]  exp_q [0:N];
    logic                special_q [0:N];
    fp64_t               special_val_q [0:N];

    logic [RW-1:0]       r_shift [1:N];
    logic [RW-1:0]       trial [1:N];
    logic                r_bit [1:N];
    fp64_t               z;

    always_comb begin
        a_exp  = a[FP_EXP_W+FP_FRAC_W-1:FP_FRAC_W];
        a_zero = (a_exp == '0); // subnormal flushed
        a_inf  = (a_exp == '1) && (a[FP_FRAC_W-1:0] == '0);
        a_nan  = (a_exp == '1) && (a[FP_FRAC_W-1:0] != '0);
        sq_odd = ~a_exp[0];     // bias is odd
        e_unb  = $signed({2'b00, a_exp}) - 13'(FP_BIAS);
        in_exp = ((e_unb - $signed({12'd0, sq_odd})) >>> 1) + 13'(FP_BIAS); // halved, rebiased

        in_special = 1'b1;
        if (a_nan || (a[63] && !a_zero)) begin
            in_special_val = FP_QNAN;                                  // negative or nan
        end else if (a_zero) begin
            in_special_val = {a[63], {(FP_EXP_W+FP_FRAC_W){1'b0}}};    // keeps -0
        end else if (a_inf) begin
            in_special_val = {1'b0, {FP_EXP_W{1'b1}}, {FP_FRAC_W{1'b0}}};
        end else begin
            in_special     = 1'b0;
            in_special_val = '0;
        end
    end

    // digit-by-digit, two radicand bits in, one root bit out
    always_comb begin
        for (int i = 1; i <= N; i++) begin
            r_shift[i] = {rem_q[i-1][RW-3:0], rad_q[i-1][RADW-1 -: 2]};
            trial[i]   = RW'({root_q[i-1], 2'b01});  // 4*root + 1
            r_bit[i]   = (r_shift[i] >= trial[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= N; i++) begin
                rad_q[i]         <= '0;
                rem_q[i]         <= '0;
                root_q[i]        <= '0;
                exp_q[i]         <= '0;
                special_q[i]     <= 1'b0;
                special_val_q[i] <= '0;
            end
            r <= '0;
        end else begin
            // odd exponent doubles the significand into [2,4)
            rad_q[0]         <= sq_odd ? {1'b1, a[FP_FRAC_W-1:0], 1'b0}
                                       : {2'b01, a[FP_FRAC_W-1:0]};
            rem_q[0]         <= '0;
            root_q[0]        <= '0;
            exp_q[0]         <= in_exp;
            special_q[0]     <= in_special;
            special_val_q[0] <= in_special_val;
            for (int i = 1; i <= N; i++) begin
                rad_q[i]         <= rad_q[i-1] << 2;  // zeros after bit pairs run out
                rem_q[i]         <= r_bit[i] ? r_shift[i] - trial[i] : r_shift[i];
                root_q[i]        <= {root_q[i-1][N-2:0], r_bit[i]};
                exp_q[i]         <= exp_q[i-1];
                special_q[i]     <= special_q[i-1];
                special_val_q[i] <= special_val_q[i-1];
            end
            r <= z; // round stage
        end
    end

    fp_round_pack i_fp_round_pack (
        .sign        (1'b0),          // negative inputs are all special
        .exp         (exp_q[N]),
        .mant        (root_q[N]),     // top bit always set
        .sticky      (|rem_q[N]),
        .special     (special_q[N]),
        .special_val (special_val_q[N]),
        .z           (z)
    );

    // negative nonzero operands have no real root
    assert property (@(posedge clk) disable iff (!rst_n)
        ((a[63] && !a_zero && !a_nan) |=> special_q[0]))
        else $error("fp_sqrt_pipe: negative operand without special flag");

endmodule

// File: hdl/pe_pkg.sv
package pe_pkg;

    // binary64 word, {sign, exponent[10:0], fraction[51:0]}
    typedef logic [63:0] fp64_t;

    // op code of the processing element
    typedef enum logic [1:0] {
        op_pass_a = 2'd0, // a delayed, bit exact
        op_pass_b = 2'd1, // b delayed, bit exact
        op_div    = 2'd2, // a / b
        op_sqrt   = 2'd3  // sqrt(a)
    } pe_op_t;

    localparam int FP_EXP_W  = 11;   // exponent field
    localparam int FP_FRAC_W = 52;   // fraction field
    localparam int FP_BIAS   = 1023; // exponent bias

    // canonical quiet NaN, positive, top fraction bit only
    localparam fp64_t FP_QNAN = {1'b0, {FP_EXP_W{1'b1}}, 1'b1, {(FP_FRAC_W-1){1'b0}}};

endpackage

// File: hdl/pe_settings.svh
`ifndef PE_SETTINGS_SVH
`define PE_SETTINGS_SVH

// cycles from operand sample to result
// 1 unpack + 56 iteration + 1 round/pack
`define PE_LATENCY 58

// quotient or root bits, one per iteration stage
// 53 significand + 1 normalization + guard + round
`define PE_ITER_BITS 56

`endif

// File: hdl/pe_type_d.sv
`include "pe_settings.svh"

module pe_type_d (
    input  logic           clk,
    input  logic           rst_n,
    input  pe_pkg::fp64_t  a,
    input  pe_pkg::fp64_t  b,
    input  pe_pkg::pe_op_t op,
    output pe_pkg::fp64_t  result
);
    import pe_pkg::*;

    fp64_t  quo;   // a / b, PE_LATENCY late
    fp64_t  root;  // sqrt(a), PE_LATENCY late
    fp64_t  a_d;
    fp64_t  b_d;
    pe_op_t op_d;  // op that belongs to the results now leaving

    fp_div_pipe i_fp_div_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .q     (quo)
    );

    fp_sqrt_pipe i_fp_sqrt_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .r     (root)
    );

    // pass-through operands, same depth as the arithmetic
    register_pipe #(.depth(`PE_LATENCY), .payload_t(fp64_t)) i_a_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (a),
        .q     (a_d)
    );

    register_pipe #(.depth(`PE_LATENCY), .payload_t(fp64_t)) i_b_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (b),
        .q     (b_d)
    );

    // op rides along so the select matches its data
    register_pipe #(.depth(`PE_LATENCY), .payload_t(pe_op_t)) i_op_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (op),
        .q     (op_d)
    );

    always_comb begin
        case (op_d)
            op_pass_a: result = a_d;
            op_pass_b: result = b_d;
            op_div:    result = quo;
            op_sqrt:   result = root;
            default:   result = a_d;  // unreachable, all codes used
        endcase
    end

    // an unknown op would leak X into result
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(op_d))
        else $error("pe_type_d: delayed op unknown");

endmodule

// File: hdl/register_pipe.sv
module register_pipe #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q [depth]; // shift chain, index 0 nearest the input

    // a zero-depth line would be a wire, not a delay
    if (depth < 1) begin : g_depth_check
        $fatal(1, "register_pipe: depth must be at least 1, got %0d", depth);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                stage_q[i] <= payload_t'(0); // zero, or first enum code
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < depth; i++) begin
                stage_q[i] <= stage_q[i-1]; // one cycle per entry
            end
        end
    end

    assign q = stage_q[depth-1];

endmodule

// File: testbench/tb_pe_type_d.sv
`include "pe_settings.svh"

module tb_pe_type_d;
    timeunit 1ns;
    timeprecision 1ps;
    import pe_pkg::*;

    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_MARGIN = 100;
    localparam int    N_RANDOM       = 500;
    localparam int    N_MIXED        = 400;
    localparam fp64_t QNAN_REF       = 64'h7ff8_0000_0000_0000; // canonical quiet nan
    localparam fp64_t POS_INF        = 64'h7ff0_0000_0000_0000;

    typedef struct packed {
        int     stamp;      // cycle in which the op is presented
        pe_op_t op;
        fp64_t  a;
        fp64_t  b;
        fp64_t  expect_val;
        bit     mixed;      // attribute the result to an op as well
    } sb_entry_t;

    logic      clk;
    logic      rst_n;
    fp64_t     a;
    fp64_t     b;
    pe_op_t    op;
    fp64_t     result;

    integer    seed = 32'h1280ceb8;
    int        cyc = 0;             // rising edges so far
    int        n_issued = 0;
    bit        first_out_seen = 1'b0;
    sb_entry_t sb_q [$];

    pe_type_d i_pe_type_d (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .op     (op),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // limit grows with the stream so a stalled run trips it
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > n_issued + RESET_CYCLES + `PE_LATENCY + TIMEOUT_MARGIN) begin
            $display("timeout after %0d cycles, results stopped draining", cyc);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic bit is_zero(fp64_t x);
        return x[62:52] == 11'h000; // subnormals count as zero
    endfunction

    function automatic bit is_inf(fp64_t x);
        return x[62:52] == 11'h7ff && x[51:0] == '0;
    endfunction

    function automatic bit is_nan(fp64_t x);
        return x[62:52] == 11'h7ff && x[51:0] != '0;
    endfunction

    // reference for one op with the special rules ahead of host double math
    function automatic fp64_t ref_result(pe_op_t o, fp64_t x, fp64_t y);
        fp64_t res;
        logic  sgn;
        sgn = x[63] ^ y[63];
        case (o)
            op_pass_a: res = x;
            op_pass_b: res = y;
            op_div: begin
                if (is_nan(x) || is_nan(y) || (is_zero(x) && is_zero(y))
                        || (is_inf(x) && is_inf(y))) begin
                    res = QNAN_REF;
                end else if (is_inf(x) || is_zero(y)) begin
                    res = {sgn, 11'h7ff, 52'h0};
                end else if (is_zero(x) || is_inf(y)) begin
                    res = {sgn, 63'h0};
                end else begin
                    res = $realtobits($bitstoreal(x) / $bitstoreal(y));
                    if (res[62:52] == 11'h000) begin
                        res = {res[63], 63'h0}; // flush tiny quotient
                    end
                end
            end
            default: begin
                if (is_nan(x)) begin
                    res = QNAN_REF;
                end else if (is_zero(x)) begin
                    res = {x[63], 63'h0};  // sqrt(-0) stays -0
                end else if (x[63]) begin
                    res = QNAN_REF;        // negative including -inf
                end else if (is_inf(x)) begin
                    res = POS_INF;
                end else begin
                    res = $realtobits($sqrt($bitstoreal(x)));
                end
            end
        endcase
        return res;
    endfunction

    // normal operand with exponent within 400 of the bias
    function automatic fp64_t rand_normal(bit allow_neg);
        int unsigned u;
        logic [51:0] f;
        logic        s;
        u = $random(seed);
        f = 52'({$random(seed), $random(seed)});
        s = allow_neg & 1'($random(seed));
        return {s, 11'(1023 - 400 + u % 801), f};
    endfunction

    task automatic check_word(fp64_t got, fp64_t expect_val);
        if (got !== expect_val) begin
            $display("ERR result got %h exp %h at cycle %0d", got, expect_val, cyc);
            $display("TEST FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_op(pe_op_t got, pe_op_t expect_op);
        if (got !== expect_op) begin
            $display("ERR result op got %h exp %h at cycle %0d", got, expect_op, cyc);
            $display("TEST FAILED");
            $fatal(1, "result belongs to another op");
        end
    endtask

    // which op the result comes from when the four candidates differ
    task automatic attribute_op(sb_entry_t ent);
        fp64_t  cand [4];
        pe_op_t got;
        bit     distinct;
        bit     found;
        distinct = 1'b1;
        found    = 1'b0;
        got      = ent.op;
        for (int k = 0; k < 4; k++) begin
            cand[k] = ref_result(pe_op_t'(2'(k)), ent.a, ent.b);
        end
        for (int k = 0; k < 4; k++) begin
            for (int m = k + 1; m < 4; m++) begin
                if (cand[k] == cand[m]) distinct = 1'b0;
            end
        end
        if (distinct) begin
            for (int k = 0; k < 4; k++) begin
                if (result == cand[k]) begin
                    got   = pe_op_t'(2'(k));
                    found = 1'b1;
                end
            end
            if (found) check_op(got, ent.op); // no match is left to check_word
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin : scoreboard
        sb_entry_t ent;
        if (rst_n) begin
            if (sb_q.size() > 0 && sb_q[0].stamp + `PE_LATENCY == cyc) begin
                ent = sb_q.pop_front();
                first_out_seen = 1'b1;
                if (ent.mixed) attribute_op(ent);
                check_word(result, ent.expect_val);
            end else if (!first_out_seen) begin
                check_word(result, '0); // pipeline still flushed from reset
            end
        end
    end

    task automatic issue_op(pe_op_t o, fp64_t x, fp64_t y, bit mixed = 1'b0);
        sb_entry_t ent;
        @(negedge clk);
        a  = x;
        b  = y;
        op = o;
        ent.stamp      = cyc;
        ent.op         = o;
        ent.a          = x;
        ent.b          = y;
        ent.expect_val = ref_result(o, x, y);
        ent.mixed      = mixed;
        sb_q.push_back(ent);
        n_issued++;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_word(result, '0); // cleared by the first reset edge
        end
        rst_n = 1'b1;
    endtask

    task automatic pass_ops();
        issue_op(op_pass_a, 64'h7ff0_0000_0000_0001, 64'h3ff0_0000_0000_0000); // snan
        issue_op(op_pass_b, 64'h3ff0_0000_0000_0000, 64'h800f_ffff_ffff_ffff); // subnormal
        issue_op(op_pass_a, 64'h0000_0000_0000_0001, 64'hfff8_0000_0000_0000);
        issue_op(op_pass_b, 64'h1234_5678_9abc_def0, 64'hfff8_0000_0000_0001);
        for (int i = 0; i < 40; i++) begin
            issue_op(pe_op_t'(2'(i % 2)), rand_normal(1'b1), rand_normal(1'b1));
        end
    endtask

    task automatic div_ops();
        issue_op(op_div, $realtobits(6.0), $realtobits(3.0));
        issue_op(op_div, $realtobits(1.0), $realtobits(3.0));
        issue_op(op_div, $realtobits(-7.5), $realtobits(2.5));
        for (int i = 0; i < N_RANDOM; i++) begin
            issue_op(op_div, rand_normal(1'b1), rand_normal(1'b1)); // back to back
        end
    endtask

    task automatic sqrt_ops();
        issue_op(op_sqrt, $realtobits(4.0), '0);
        issue_op(op_sqrt, $realtobits(9.0), '0);
        issue_op(op_sqrt, $realtobits(144.0), '0);
        issue_op(op_sqrt, $realtobits(0.25), '0);   // even exponent below one
        issue_op(op_sqrt, $realtobits(2.0), '0);
        issue_op(op_sqrt, $realtobits(1.0e10), '0);
        for (int i = 0; i < N_RANDOM; i++) begin
            issue_op(op_sqrt, rand_normal(1'b0), rand_normal(1'b1));
        end
    endtask

    task automatic special_ops();
        issue_op(op_div, $realtobits(5.0), '0);                 // +inf
        issue_op(op_div, $realtobits(-5.0), '0);                // -inf
        issue_op(op_div, '0, 64'h8000_0000_0000_0000);          // 0/0
        issue_op(op_div, POS_INF, 64'hfff0_0000_0000_0000);     // inf/inf
        issue_op(op_div, 64'h7ff0_0000_0000_0001, $realtobits(2.0));
        issue_op(op_div, $realtobits(2.0), 64'hfff8_0000_0000_0000);
        issue_op(op_div, 64'h0000_0000_0000_0001, $realtobits(2.0)); // subnormal dividend
        issue_op(op_div, $realtobits(-3.0), POS_INF);           // -0
        issue_op(op_sqrt, 64'h7ff8_0000_0000_0123, '0);
        issue_op(op_sqrt, $realtobits(-1.0), '0);
        issue_op(op_sqrt, 64'h8000_0000_0000_0000, '0);         // -0
        issue_op(op_sqrt, POS_INF, '0);
        issue_op(op_sqrt, 64'hfff0_0000_0000_0000, '0);         // -inf
    endtask

    task automatic mixed_ops();
        for (int i = 0; i < N_MIXED; i++) begin
            issue_op(pe_op_t'(2'($random(seed))), rand_normal(1'b1), rand_normal(1'b1), 1'b1);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        a     = '0;
        b     = '0;
        op    = op_pass_a;
        apply_reset();
        pass_ops();
        div_ops();
        sqrt_ops();
        special_ops();
        mixed_ops();
        @(negedge clk);
        a  = '0;
        b  = '0;
        op = op_pass_a;
        while (sb_q.size() > 0) begin
            @(negedge clk); // drain under the watchdog
        end
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule
